/* bus_pkg.sv */
package bus_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] word_t;

    // ----------------------------------------------------------------------
    // wishbone classic bundles
    // ----------------------------------------------------------------------
    // master to slave
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        word_t dat;
    } wb_req_t;

    // slave to master without err
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

endpackage

/* dma_backend.sv */
module dma_backend (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  dma_pkg::transfer_req_t i_req,
    input  logic                   i_req_valid,
    output logic                   o_req_ready,
    output bus_pkg::wb_req_t       o_wb,
    input  bus_pkg::wb_rsp_t       i_wb,
    output logic                   o_done,
    output logic                   o_idle
);

    dma_pkg::transfer_req_t req_head;
    logic                   req_full;
    logic                   req_empty;
    logic                   req_pop;
    logic                   load;
    logic                   chunk_start;
    logic                   phase_write;
    logic                   zero_len;
    logic                   last_beat;
    logic                   last_chunk;
    logic                   start;
    logic                   we;
    logic                   access_done;
    logic                   beat;
    bus_pkg::addr_t         addr;
    bus_pkg::word_t         rdata;
    bus_pkg::word_t         wdata;

    assign o_req_ready = !req_full;

    // ----------------------------------------------------------------------
    // request queue
    // ----------------------------------------------------------------------
    dma_queue #(
        .payload_t ( dma_pkg::transfer_req_t ),
        .DEPTH     ( dma_pkg::REQ_DEPTH      )
    ) req_queue_i (
        .clk_i   ( clk_i                      ),
        .rst_ni  ( rst_ni                     ),
        .i_push  ( i_req_valid && o_req_ready ),
        .i_data  ( i_req                      ),
        .i_pop   ( req_pop                    ),
        .o_data  ( req_head                   ),
        .o_full  ( req_full                   ),
        .o_empty ( req_empty                  )
    );

    // ----------------------------------------------------------------------
    // sequencing
    // ----------------------------------------------------------------------
    dma_chunk_counter chunk_counter_i (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .i_load        ( load        ),
        .i_req         ( req_head    ),
        .i_beat        ( beat        ),
        .i_phase_write ( phase_write ),
        .i_chunk_start ( chunk_start ),
        .o_addr        ( addr        ),
        .o_last_beat   ( last_beat   ),
        .o_last_chunk  ( last_chunk  ),
        .o_zero_len    ( zero_len    )
    );

    dma_ctrl_fsm ctrl_fsm_i (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .i_req_empty   ( req_empty   ),
        .o_req_pop     ( req_pop     ),
        .o_load        ( load        ),
        .o_chunk_start ( chunk_start ),
        .o_phase_write ( phase_write ),
        .i_zero_len    ( zero_len    ),
        .i_last_beat   ( last_beat   ),
        .i_last_chunk  ( last_chunk  ),
        .o_start       ( start       ),
        .o_we          ( we          ),
        .i_access_done ( access_done ),
        .o_beat        ( beat        ),
        .o_done        ( o_done      ),
        .o_idle        ( o_idle      )
    );

    // ----------------------------------------------------------------------
    // data path
    // ----------------------------------------------------------------------
    // read words fill the buffer and write words drain it
    dma_queue #(
        .payload_t ( bus_pkg::word_t      ),
        .DEPTH     ( dma_pkg::BURST_WORDS )
    ) data_buffer_i (
        .clk_i   ( clk_i                       ),
        .rst_ni  ( rst_ni                      ),
        .i_push  ( access_done && !phase_write ),
        .i_data  ( rdata                       ),
        .i_pop   ( access_done && phase_write  ),
        .o_data  ( wdata                       ),
        .o_full  (                             ),
        .o_empty (                             )
    );

    dma_wb_master wb_master_i (
        .clk_i   ( clk_i       ),
        .rst_ni  ( rst_ni      ),
        .i_start ( start       ),
        .i_we    ( we          ),
        .i_addr  ( addr        ),
        .i_wdata ( wdata       ),
        .o_rdata ( rdata       ),
        .o_done  ( access_done ),
        .o_wb    ( o_wb        ),
        .i_wb    ( i_wb        )
    );

endmodule

/* dma_chunk_counter.sv */
module dma_chunk_counter (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   i_load,
    input  dma_pkg::transfer_req_t i_req,
    input  logic                   i_beat,
    input  logic                   i_phase_write,
    input  logic                   i_chunk_start,
    output bus_pkg::addr_t         o_addr,
    output logic                   o_last_beat,
    output logic                   o_last_chunk,
    output logic                   o_zero_len
);

    bus_pkg::addr_t      src_q;
    bus_pkg::addr_t      dst_q;
    dma_pkg::len_t       remain_q;
    dma_pkg::chunk_len_t chunk_len_q;
    dma_pkg::chunk_len_t beat_q;
    dma_pkg::len_t       src_to_pb;
    dma_pkg::len_t       dst_to_pb;
    dma_pkg::len_t       chunk_max;
    logic                advance;

    // ----------------------------------------------------------------------
    // chunk sizing
    // ----------------------------------------------------------------------
    always_comb begin
        src_to_pb = dma_pkg::len_t'(dma_pkg::PAGE_WORDS)
                  - dma_pkg::len_t'(src_q[dma_pkg::PAGE_OFFS_WIDTH-1:0]);
        dst_to_pb = dma_pkg::len_t'(dma_pkg::PAGE_WORDS)
                  - dma_pkg::len_t'(dst_q[dma_pkg::PAGE_OFFS_WIDTH-1:0]);
        chunk_max = dma_pkg::len_t'(dma_pkg::BURST_WORDS);
        if (remain_q < chunk_max) begin
            chunk_max = remain_q;
        end
        // neither side may cross its page
        if (src_to_pb < chunk_max) begin
            chunk_max = src_to_pb;
        end
        if (dst_to_pb < chunk_max) begin
            chunk_max = dst_to_pb;
        end
    end

    assign o_zero_len   = (remain_q == '0);
    assign o_last_beat  = (beat_q == chunk_len_q - dma_pkg::chunk_len_t'(1));
    assign o_last_chunk = (remain_q == dma_pkg::len_t'(chunk_len_q));
    assign o_addr       = (i_phase_write ? dst_q : src_q) + bus_pkg::addr_t'(beat_q);

    // end of write phase moves the window on
    assign advance = i_beat && o_last_beat && i_phase_write;

    always_ff @(posedge clk_i) begin
        if (i_load) begin
            src_q <= i_req.src;
            dst_q <= i_req.dst;
        end else if (advance) begin
            src_q <= src_q + bus_pkg::addr_t'(chunk_len_q);
            dst_q <= dst_q + bus_pkg::addr_t'(chunk_len_q);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            remain_q    <= '0;
            chunk_len_q <= '0;
            beat_q      <= '0;
        end else if (i_load) begin
            remain_q <= i_req.num_words;
            beat_q   <= '0;
        end else if (i_chunk_start) begin
            chunk_len_q <= dma_pkg::chunk_len_t'(chunk_max);
            beat_q      <= '0;
        end else if (i_beat) begin
            beat_q <= o_last_beat ? '0 : beat_q + dma_pkg::chunk_len_t'(1);
            if (advance) begin
                remain_q <= remain_q - dma_pkg::len_t'(chunk_len_q);
            end
        end
    end

endmodule

/* dma_ctrl_fsm.sv */
module dma_ctrl_fsm (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic i_req_empty,
    output logic o_req_pop,
    output logic o_load,
    output logic o_chunk_start,
    output logic o_phase_write,
    input  logic i_zero_len,
    input  logic i_last_beat,
    input  logic i_last_chunk,
    output logic o_start,
    output logic o_we,
    input  logic i_access_done,
    output logic o_beat,
    output logic o_done,
    output logic o_idle
);

    dma_pkg::ctrl_state_t state_q;
    dma_pkg::ctrl_state_t state_d;
    // an access is outstanding on the bus
    logic                 busy_q;
    logic                 busy_d;
    // first cycle of a read phase sizes the chunk
    logic                 fresh_q;
    logic                 fresh_d;

    assign o_phase_write = (state_q == dma_pkg::WRITE);
    assign o_we          = (state_q == dma_pkg::WRITE);
    assign o_done        = (state_q == dma_pkg::DONE);
    assign o_idle        = (state_q == dma_pkg::IDLE) && i_req_empty;

    always_comb begin
        state_d       = state_q;
        busy_d        = busy_q;
        fresh_d       = fresh_q;
        o_req_pop     = 1'b0;
        o_load        = 1'b0;
        o_chunk_start = 1'b0;
        o_start       = 1'b0;
        o_beat        = 1'b0;
        case (state_q)
            dma_pkg::IDLE: begin
                if (!i_req_empty) begin
                    o_req_pop = 1'b1;
                    o_load    = 1'b1;
                    state_d   = dma_pkg::LOAD;
                end
            end
            dma_pkg::LOAD: begin
                if (i_zero_len) begin
                    state_d = dma_pkg::DONE;
                end else begin
                    state_d = dma_pkg::READ;
                    fresh_d = 1'b1;
                end
            end
            dma_pkg::READ, dma_pkg::WRITE: begin
                if (fresh_q) begin
                    o_chunk_start = 1'b1;
                    fresh_d       = 1'b0;
                end else if (!busy_q) begin
                    o_start = 1'b1;
                    busy_d  = 1'b1;
                end else if (i_access_done) begin
                    o_beat = 1'b1;
                    busy_d = 1'b0;
                    if (i_last_beat) begin
                        if (state_q == dma_pkg::READ) begin
                            state_d = dma_pkg::WRITE;
                        end else if (i_last_chunk) begin
                            state_d = dma_pkg::DONE;
                        end else begin
                            state_d = dma_pkg::READ;
                            fresh_d = 1'b1;
                        end
                    end
                end
            end
            default: begin
                state_d = dma_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            state_q <= dma_pkg::IDLE;
            busy_q  <= 1'b0;
            fresh_q <= 1'b0;
        end else begin
            state_q <= state_d;
            busy_q  <= busy_d;
            fresh_q <= fresh_d;
        end
    end

endmodule

/* dma_pkg.sv */
package dma_pkg;

    // ----------------------------------------------------------------------
    // transfer request
    // ----------------------------------------------------------------------
    localparam int LEN_WIDTH = 12;

    typedef logic [LEN_WIDTH-1:0] len_t;

    // word addresses and a length in words
    typedef struct packed {
        bus_pkg::addr_t src;
        bus_pkg::addr_t dst;
        len_t           num_words;
    } transfer_req_t;

    // ----------------------------------------------------------------------
    // sizing
    // ----------------------------------------------------------------------
    localparam int REQ_DEPTH       = 4;
    localparam int BURST_WORDS     = 8;
    // must stay a power of two
    localparam int PAGE_WORDS      = 16;
    localparam int PAGE_OFFS_WIDTH = $clog2(PAGE_WORDS);

    // holds up to BURST_WORDS
    typedef logic [3:0] chunk_len_t;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        READ,
        WRITE,
        DONE
    } ctrl_state_t;

endpackage

/* dma_queue.sv */
module dma_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     i_push,
    input  payload_t i_data,
    input  logic     i_pop,
    output payload_t o_data,
    output logic     o_full,
    output logic     o_empty
);

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(DEPTH):0]   cnt_t;

    payload_t mem_q [DEPTH];
    ptr_t     rd_ptr_q;
    ptr_t     wr_ptr_q;
    cnt_t     count_q;
    logic     push_en;
    logic     pop_en;

    assign o_full  = (count_q == cnt_t'(DEPTH));
    assign o_empty = (count_q == '0);
    assign push_en = i_push && !o_full;
    assign pop_en  = i_pop && !o_empty;

    // head of queue is always visible
    assign o_data = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_en) begin
            mem_q[wr_ptr_q] <= i_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
            end
            if (pop_en) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
            end
            // simultaneous push and pop keep the count
            case ({push_en, pop_en})
                2'b10:   count_q <= count_q + cnt_t'(1);
                2'b01:   count_q <= count_q - cnt_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* dma_testdata.txt */
# f <fill key hex>: word at address a is key ^ {~a, a}
# t <test> <src hex> <dst hex> <len dec>, e <test> <expected done pulses>
f 5a5a0000
t 1 0100 0200 5
t 2 030d 0400 20
t 3 1000 2000 6
t 3 1010 2010 3
t 3 1020 2020 10
t 3 1030 2030 2
t 3 1040 2040 7
t 3 1050 2050 4
t 4 0600 0700 0
t 5 0800 0900 4
e 1 1
e 2 1
e 3 6
e 4 1
e 5 1

/* dma_wb_master.sv */
module dma_wb_master (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             i_start,
    input  logic             i_we,
    input  bus_pkg::addr_t   i_addr,
    input  bus_pkg::word_t   i_wdata,
    output bus_pkg::word_t   o_rdata,
    output logic             o_done,
    output bus_pkg::wb_req_t o_wb,
    input  bus_pkg::wb_rsp_t i_wb
);

    // cyc and stb rise and fall together
    logic           active_q;
    logic           done_q;
    logic           we_q;
    bus_pkg::addr_t adr_q;
    bus_pkg::word_t dat_q;
    bus_pkg::word_t rdata_q;
    logic           acked;
    logic           launch;

    assign acked  = active_q && i_wb.ack;
    assign launch = i_start && !active_q;

    assign o_wb = '{
        cyc: active_q,
        stb: active_q,
        we:  we_q,
        adr: adr_q,
        dat: dat_q
    };
    assign o_rdata = rdata_q;
    assign o_done  = done_q;

    // ----------------------------------------------------------------------
    // access control
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_ni) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= acked;
            if (acked) begin
                active_q <= 1'b0;
            end else if (launch) begin
                active_q <= 1'b1;
            end
        end
    end

    // address and data held stable until ack
    always_ff @(posedge clk_i) begin
        if (launch) begin
            we_q  <= i_we;
            adr_q <= i_addr;
            dat_q <= i_wdata;
        end
        if (acked && !we_q) begin
            rdata_q <= i_wb.dat;
        end
    end

endmodule

/* tb.f */
bus_pkg.sv
dma_pkg.sv
dma_queue.sv
dma_chunk_counter.sv
dma_ctrl_fsm.sv
dma_wb_master.sv
dma_backend.sv
tb_wb_memory.sv
tb_dma_backend.sv

/* tb_dma_backend.sv */
module tb_dma_backend;

    logic                   clk_i;
    logic                   rst_ni;
    dma_pkg::transfer_req_t i_req;
    logic                   i_req_valid;
    logic                   o_req_ready;
    bus_pkg::wb_req_t       wb_req;
    bus_pkg::wb_rsp_t       wb_rsp;
    logic                   o_done;
    logic                   o_idle;

    // reference memory and transfer list from the data file
    bus_pkg::word_t model [2**bus_pkg::ADDR_WIDTH];
    logic [31:0]    fill_key;
    int             tr_test[$];
    int             tr_src[$];
    int             tr_dst[$];
    int             tr_len[$];
    int             exp_done [16];
    int             num_tests;

    int   error_count;
    int   done_count;
    int   stb_count;
    logic stb_prev;
    logic full_seen;
    int   cycles;
    int   cycle_limit;
    int   run_len;
    logic run_we;
    int   run_page;

    dma_backend dma_backend_i (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .i_req       ( i_req       ),
        .i_req_valid ( i_req_valid ),
        .o_req_ready ( o_req_ready ),
        .o_wb        ( wb_req      ),
        .i_wb        ( wb_rsp      ),
        .o_done      ( o_done      ),
        .o_idle      ( o_idle      )
    );

    tb_wb_memory mem_i (
        .clk_i  ( clk_i  ),
        .rst_ni ( rst_ni ),
        .i_wb   ( wb_req ),
        .o_wb   ( wb_rsp )
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    function automatic bus_pkg::word_t fill_word(input int a);
        logic [15:0] adr;
        adr = a[15:0];
        return fill_key ^ {~adr, adr};
    endfunction

    // ----------------------------------------------------------------------
    // bus and completion monitors
    // ----------------------------------------------------------------------
    always @(posedge clk_i) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    always @(posedge clk_i) begin
        if (wb_req.stb && !stb_prev) begin
            stb_count++;
        end
        stb_prev = wb_req.stb;
        if (!rst_ni && o_done) begin
            done_count++;
        end
    end

    // runs of same-direction accesses must respect burst and page limits
    always @(posedge clk_i) begin
        if (wb_req.stb && wb_rsp.ack) begin
            if (run_len != 0 && wb_req.we == run_we) begin
                run_len++;
                check_value($sformatf("%s run leaves page at %04h",
                            run_we ? "write" : "read", wb_req.adr),
                            int'(wb_req.adr) / dma_pkg::PAGE_WORDS, run_page);
                check_value("access run longer than a burst",
                            run_len <= dma_pkg::BURST_WORDS, 1);
            end else begin
                run_we   = wb_req.we;
                run_len  = 1;
                run_page = int'(wb_req.adr) / dma_pkg::PAGE_WORDS;
            end
        end
    end

    // ----------------------------------------------------------------------
    // test data and stimulus
    // ----------------------------------------------------------------------
    task automatic load_testdata();
        int    fd;
        string line;
        byte   kind;
        int    t;
        int    a;
        int    b;
        int    n;
        fd = $fopen("dma_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open dma_testdata.txt");
            error_count++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                kind = line.getc(0);
                if (kind == "f") begin
                    void'($sscanf(line, "%c %h", kind, fill_key));
                end else if (kind == "t") begin
                    void'($sscanf(line, "%c %d %h %h %d", kind, t, a, b, n));
                    tr_test.push_back(t);
                    tr_src.push_back(a);
                    tr_dst.push_back(b);
                    tr_len.push_back(n);
                    cycle_limit += 2 * n * 6 + 20;
                    if (t > num_tests) begin
                        num_tests = t;
                    end
                end else if (kind == "e") begin
                    void'($sscanf(line, "%c %d %d", kind, t, n));
                    exp_done[t] = n;
                end
            end
            $fclose(fd);
            cycle_limit = 2 * cycle_limit + 16;
        end
    endtask

    // waits at falling edges while the queue is full
    task automatic send_request(input dma_pkg::transfer_req_t req);
        @(negedge clk_i);
        i_req       = req;
        i_req_valid = 1'b1;
        while (!o_req_ready) begin
            full_seen = 1'b1;
            @(negedge clk_i);
        end
        @(posedge clk_i);
    endtask

    task automatic run_test(input int t, inout int tests_ok, inout int tests_bad);
        dma_pkg::transfer_req_t req;
        int done_target;
        int stb_before;
        int errors_before;
        int words;
        int n;
        errors_before = error_count;
        stb_before    = stb_count;
        done_target   = done_count + exp_done[t];
        words         = 0;
        n             = 0;
        full_seen     = 1'b0;
        foreach (tr_test[k]) begin
            if (tr_test[k] == t) begin
                req.src       = bus_pkg::addr_t'(tr_src[k]);
                req.dst       = bus_pkg::addr_t'(tr_dst[k]);
                req.num_words = dma_pkg::len_t'(tr_len[k]);
                send_request(req);
                // copy rule in ascending word order
                for (int i = 0; i < tr_len[k]; i++) begin
                    model[tr_dst[k] + i] = model[tr_src[k] + i];
                end
                words += tr_len[k];
                n++;
            end
        end
        @(negedge clk_i);
        i_req_valid = 1'b0;
        check_value("o_idle after request accepted", o_idle, 0);
        while (done_count < done_target) begin
            @(negedge clk_i);
        end
        check_value("o_idle after last done", o_idle, 1);
        repeat (3) @(negedge clk_i);
        check_value($sformatf("test %0d done pulses", t), done_count, done_target);
        check_value($sformatf("test %0d bus accesses", t), stb_count - stb_before, 2 * words);
        if (n > dma_pkg::REQ_DEPTH) begin
            check_value("o_req_ready low while queue full", full_seen, 1);
        end
        foreach (tr_test[k]) begin
            if (tr_test[k] == t) begin
                for (int i = 0; i < tr_len[k]; i++) begin
                    check_value($sformatf("test %0d word at %04h", t, tr_dst[k] + i),
                                mem_i.mem[tr_dst[k] + i], model[tr_dst[k] + i]);
                end
            end
        end
        if (error_count == errors_before) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("test %0d: %0d transfer(s), %0d words, %s", t, n, words,
                 (error_count == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int tests_ok;
        int tests_bad;
        rst_ni      = 1'b1;
        i_req       = '0;
        i_req_valid = 1'b0;
        error_count = 0;
        done_count  = 0;
        stb_count   = 0;
        stb_prev    = 1'b0;
        full_seen   = 1'b0;
        cycles      = 0;
        cycle_limit = 0;
        run_len     = 0;
        run_we      = 1'b0;
        run_page    = 0;
        num_tests   = 0;
        fill_key    = '0;
        tests_ok    = 0;
        tests_bad   = 0;
        foreach (exp_done[i]) begin
            exp_done[i] = 0;
        end
        load_testdata();
        for (int a = 0; a < 2**bus_pkg::ADDR_WIDTH; a++) begin
            model[a]     = fill_word(a);
            mem_i.mem[a] = fill_word(a);
        end
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b0;
        @(negedge clk_i);
        check_value("o_idle after reset", o_idle, 1);
        check_value("o_req_ready after reset", o_req_ready, 1);
        for (int t = 1; t <= num_tests; t++) begin
            run_test(t, tests_ok, tests_bad);
        end
        $display("summary: %0d tests ok, %0d tests failed, %0d errors",
                 tests_ok, tests_bad, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* tb_wb_memory.sv */
module tb_wb_memory (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  bus_pkg::wb_req_t i_wb,
    output bus_pkg::wb_rsp_t o_wb
);

    // full word address space loaded by the testbench
    bus_pkg::word_t mem [2**bus_pkg::ADDR_WIDTH];

    logic [16:0]    lfsr_q;
    logic           busy_q;
    logic           ack_q;
    logic [1:0]     wait_q;
    bus_pkg::word_t rdat_q;

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    assign o_wb = '{ack: ack_q, dat: rdat_q};

    always @(posedge clk_i) begin
        logic [16:0] s1;
        logic [16:0] s2;
        s1 = lfsr_next(lfsr_q);
        s2 = lfsr_next(s1);
        ack_q <= 1'b0;
        if (rst_ni) begin
            busy_q <= 1'b0;
            wait_q <= '0;
            lfsr_q <= 17'd95184;
        end else if (i_wb.cyc && i_wb.stb && !ack_q) begin
            if (!busy_q) begin
                // two fresh bits give 0 to 3 wait states
                busy_q <= 1'b1;
                wait_q <= {s1[0], s2[0]};
                lfsr_q <= s2;
            end else if (wait_q == 2'd0) begin
                busy_q <= 1'b0;
                ack_q  <= 1'b1;
                rdat_q <= mem[i_wb.adr];
                if (i_wb.we) begin
                    mem[i_wb.adr] <= i_wb.dat;
                end
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

endmodule
